// ==== barrel_pkg.sv ====
/* shared widths, opcodes, ALU and write-back codes, thread index type
   and the instruction word union for the barrel-threaded core */
package barrel_pkg;

  localparam int XLEN        = 32;
  localparam int NUM_THREADS = 8;
  localparam int THREAD_W    = 3;
  localparam int REG_ADDR_W  = 5;
  localparam int ROM_ADDR_W  = 10;
  localparam int DMEM_ADDR_W = 14;

  typedef logic [THREAD_W-1:0] thread_t;

  // ------------------------------
  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ------------------------------
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLT    = 4'd5;
  localparam alu_op_t ALU_SLTU   = 4'd6;
  localparam alu_op_t ALU_SLL    = 4'd7;
  localparam alu_op_t ALU_SRL    = 4'd8;
  localparam alu_op_t ALU_SRA    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // write-back source
  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_MEM  = 2'd1;
  localparam wb_sel_t WB_LINK = 2'd2;

  // ------------------------------
  // one instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_u;

endpackage

// ==== rf_wr_if.sv ====
/* register write-back bus, driven by write-back, taken by the register banks */
`timescale 1ns/1ns

interface rf_wr_if;

  logic                                wr_en;
  barrel_pkg::thread_t                 thread;
  logic [barrel_pkg::REG_ADDR_W-1:0]   addr;
  logic [barrel_pkg::XLEN-1:0]         data;

  modport src (
    output wr_en, thread, addr, data
  );

  modport dst (
    input wr_en, thread, addr, data
  );

endinterface

// ==== thread_fetch.sv ====
/* round-robin thread counter, start delay, per-thread PCs and fetch address */
`timescale 1ns/1ns

module thread_fetch (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_pc_wr_en,
  input  barrel_pkg::thread_t                 i_pc_wr_thread,
  input  logic [barrel_pkg::XLEN-1:0]         i_pc_wr_data,
  output logic [barrel_pkg::ROM_ADDR_W-1:0]   o_rom_addr,
  output logic                                o_valid,
  output barrel_pkg::thread_t                 o_thread,
  output logic [barrel_pkg::XLEN-1:0]         o_pc
);

  logic                         started_q;
  barrel_pkg::thread_t          cnt_q;
  logic [barrel_pkg::XLEN-1:0]  pc_q [barrel_pkg::NUM_THREADS];

  // first fetch one cycle after reset drops
  always_ff @(posedge clk) begin
    if (reset) begin
      started_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      started_q <= 1'b1;
      if (started_q) begin
        if (cnt_q == barrel_pkg::thread_t'(barrel_pkg::NUM_THREADS - 1)) begin
          cnt_q <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // pc update comes back from execute, 2 cycles after the fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < barrel_pkg::NUM_THREADS; i++) begin
        pc_q[i] <= '0;
      end
    end else if (i_pc_wr_en) begin
      pc_q[i_pc_wr_thread] <= i_pc_wr_data;
    end
  end

  // word address into the instruction ROM
  assign o_rom_addr = pc_q[cnt_q][barrel_pkg::ROM_ADDR_W+1:2];

  // line up with the ROM word
  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= started_q;
    end
    o_thread <= cnt_q;
    o_pc     <= pc_q[cnt_q];
  end

endmodule

// ==== inst_decode.sv ====
/* field extraction, immediates, control decode and the ID/EX register */
`timescale 1ns/1ns

module inst_decode (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_valid,
  input  barrel_pkg::thread_t                 i_thread,
  input  logic [barrel_pkg::XLEN-1:0]         i_pc,
  input  logic [barrel_pkg::XLEN-1:0]         i_inst,
  input  logic [barrel_pkg::XLEN-1:0]         i_rs1_data,
  input  logic [barrel_pkg::XLEN-1:0]         i_rs2_data,
  output logic [barrel_pkg::REG_ADDR_W-1:0]   o_rs1_addr,
  output logic [barrel_pkg::REG_ADDR_W-1:0]   o_rs2_addr,
  output barrel_pkg::thread_t                 o_rs_thread,
  output logic                                o_ex_valid,
  output barrel_pkg::thread_t                 o_ex_thread,
  output logic [barrel_pkg::XLEN-1:0]         o_ex_pc,
  output logic [barrel_pkg::XLEN-1:0]         o_ex_rs1,
  output logic [barrel_pkg::XLEN-1:0]         o_ex_rs2,
  output logic [barrel_pkg::XLEN-1:0]         o_ex_imm,
  output barrel_pkg::alu_op_t                 o_ex_alu_op,
  output logic                                o_ex_src_a_pc,
  output logic                                o_ex_src_b_imm,
  output logic [2:0]                          o_ex_funct3,
  output logic                                o_ex_is_branch,
  output logic                                o_ex_is_jump,
  output logic                                o_ex_is_jalr,
  output logic                                o_ex_is_store,
  output barrel_pkg::wb_sel_t                 o_ex_wb_sel,
  output logic [barrel_pkg::REG_ADDR_W-1:0]   o_ex_rd,
  output logic                                o_ex_rd_we
);

  barrel_pkg::inst_u            inst;
  logic [barrel_pkg::XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  barrel_pkg::alu_op_t          alu_op, funct_op;
  barrel_pkg::wb_sel_t          wb_sel;
  logic                         src_a_pc, src_b_imm, is_branch, is_jump, is_jalr;
  logic                         is_store, rd_we;

  assign inst = i_inst;

  // ------------------------------
  // register read, same cycle
  assign o_rs1_addr  = inst.r_fmt.rs1;
  assign o_rs2_addr  = inst.r_fmt.rs2;
  assign o_rs_thread = i_thread;

  // immediates per format
  assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  // funct3 to ALU op, SUB only for the register form
  always_comb begin
    case (inst.r_fmt.funct3)
      3'b000: funct_op = (inst.r_fmt.opcode == barrel_pkg::OPC_OP && inst.r_fmt.funct7[5])
                         ? barrel_pkg::ALU_SUB : barrel_pkg::ALU_ADD;
      3'b001: funct_op = barrel_pkg::ALU_SLL;
      3'b010: funct_op = barrel_pkg::ALU_SLT;
      3'b011: funct_op = barrel_pkg::ALU_SLTU;
      3'b100: funct_op = barrel_pkg::ALU_XOR;
      3'b101: funct_op = inst.r_fmt.funct7[5] ? barrel_pkg::ALU_SRA : barrel_pkg::ALU_SRL;
      3'b110: funct_op = barrel_pkg::ALU_OR;
      default: funct_op = barrel_pkg::ALU_AND;
    endcase
  end

  // ------------------------------
  // control decode, anything else is a no-op
  always_comb begin
    alu_op    = barrel_pkg::ALU_ADD;
    imm       = imm_i;
    src_a_pc  = 1'b0;
    src_b_imm = 1'b1;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;
    is_store  = 1'b0;
    wb_sel    = barrel_pkg::WB_ALU;
    rd_we     = 1'b0;
    case (inst.r_fmt.opcode)
      barrel_pkg::OPC_OP: begin
        alu_op    = funct_op;
        src_b_imm = 1'b0;
        rd_we     = 1'b1;
      end
      barrel_pkg::OPC_OP_IMM: begin
        alu_op = funct_op;
        rd_we  = 1'b1;
      end
      barrel_pkg::OPC_LUI: begin
        alu_op = barrel_pkg::ALU_PASS_B;
        imm    = imm_u;
        rd_we  = 1'b1;
      end
      barrel_pkg::OPC_AUIPC: begin
        imm      = imm_u;
        src_a_pc = 1'b1;
        rd_we    = 1'b1;
      end
      barrel_pkg::OPC_JAL: begin
        imm      = imm_j;
        src_a_pc = 1'b1;
        is_jump  = 1'b1;
        wb_sel   = barrel_pkg::WB_LINK;
        rd_we    = 1'b1;
      end
      barrel_pkg::OPC_JALR: begin
        is_jump = 1'b1;
        is_jalr = 1'b1;
        wb_sel  = barrel_pkg::WB_LINK;
        rd_we   = 1'b1;
      end
      barrel_pkg::OPC_BRANCH: begin
        // ALU forms the target, compare is separate
        imm       = imm_b;
        src_a_pc  = 1'b1;
        is_branch = 1'b1;
      end
      barrel_pkg::OPC_LOAD: begin
        wb_sel = barrel_pkg::WB_MEM;
        rd_we  = 1'b1;
      end
      barrel_pkg::OPC_STORE: begin
        imm      = imm_s;
        is_store = 1'b1;
      end
      default: ;
    endcase
  end

  // ------------------------------
  // ID/EX register
  always_ff @(posedge clk) begin
    if (reset) begin
      o_ex_valid    <= 1'b0;
      o_ex_rd_we    <= 1'b0;
      o_ex_is_store <= 1'b0;
    end else begin
      o_ex_valid    <= i_valid;
      o_ex_rd_we    <= i_valid & rd_we & (inst.r_fmt.rd != '0);
      o_ex_is_store <= i_valid & is_store;
    end
    o_ex_thread    <= i_thread;
    o_ex_pc        <= i_pc;
    o_ex_rs1       <= i_rs1_data;
    o_ex_rs2       <= i_rs2_data;
    o_ex_imm       <= imm;
    o_ex_alu_op    <= alu_op;
    o_ex_src_a_pc  <= src_a_pc;
    o_ex_src_b_imm <= src_b_imm;
    o_ex_funct3    <= inst.r_fmt.funct3;
    o_ex_is_branch <= is_branch;
    o_ex_is_jump   <= is_jump;
    o_ex_is_jalr   <= is_jalr;
    o_ex_wb_sel    <= wb_sel;
    o_ex_rd        <= inst.r_fmt.rd;
  end

endmodule

// ==== thread_regfile.sv ====
/* per-thread register banks, two combinational reads and one write */
`timescale 1ns/1ns

module thread_regfile (
  input  logic                                clk,
  input  barrel_pkg::thread_t                 i_rd_thread,
  input  logic [barrel_pkg::REG_ADDR_W-1:0]   i_rs1_addr,
  input  logic [barrel_pkg::REG_ADDR_W-1:0]   i_rs2_addr,
  output logic [barrel_pkg::XLEN-1:0]         o_rs1_data,
  output logic [barrel_pkg::XLEN-1:0]         o_rs2_data,
  rf_wr_if.dst                                wr
);

  localparam int NUM_REGS = 2 ** barrel_pkg::REG_ADDR_W;

  logic [barrel_pkg::XLEN-1:0] bank_q [barrel_pkg::NUM_THREADS][NUM_REGS];

  // x0 is never written, so force the read
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : bank_q[i_rd_thread][i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : bank_q[i_rd_thread][i_rs2_addr];

  // write-back thread is always a different one than the reader
  always_ff @(posedge clk) begin
    if (wr.wr_en) begin
      bank_q[wr.thread][wr.addr] <= wr.data;
    end
  end

endmodule

// ==== execute_unit.sv ====
/* ALU, branch compare, next-PC and the EX/MEM register */
`timescale 1ns/1ns

module execute_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_valid,
  input  barrel_pkg::thread_t                 i_thread,
  input  logic [barrel_pkg::XLEN-1:0]         i_pc,
  input  logic [barrel_pkg::XLEN-1:0]         i_rs1,
  input  logic [barrel_pkg::XLEN-1:0]         i_rs2,
  input  logic [barrel_pkg::XLEN-1:0]         i_imm,
  input  barrel_pkg::alu_op_t                 i_alu_op,
  input  logic                                i_src_a_pc,
  input  logic                                i_src_b_imm,
  input  logic [2:0]                          i_funct3,
  input  logic                                i_is_branch,
  input  logic                                i_is_jump,
  input  logic                                i_is_jalr,
  input  logic                                i_is_store,
  input  barrel_pkg::wb_sel_t                 i_wb_sel,
  input  logic [barrel_pkg::REG_ADDR_W-1:0]   i_rd,
  input  logic                                i_rd_we,
  output logic                                o_pc_wr_en,
  output barrel_pkg::thread_t                 o_pc_wr_thread,
  output logic [barrel_pkg::XLEN-1:0]         o_pc_wr_data,
  output logic                                o_mem_valid,
  output barrel_pkg::thread_t                 o_mem_thread,
  output logic [barrel_pkg::XLEN-1:0]         o_mem_result,
  output logic [barrel_pkg::XLEN-1:0]         o_mem_store_data,
  output logic                                o_mem_is_store,
  output barrel_pkg::wb_sel_t                 o_mem_wb_sel,
  output logic [barrel_pkg::XLEN-1:0]         o_mem_link,
  output logic [barrel_pkg::REG_ADDR_W-1:0]   o_mem_rd,
  output logic                                o_mem_rd_we
);

  logic [barrel_pkg::XLEN-1:0] op_a, op_b, result, link, target;
  logic                        taken, br_cond;

  assign op_a = i_src_a_pc  ? i_pc  : i_rs1;
  assign op_b = i_src_b_imm ? i_imm : i_rs2;

  // ------------------------------
  always_comb begin
    case (i_alu_op)
      barrel_pkg::ALU_SUB:    result = op_a - op_b;
      barrel_pkg::ALU_AND:    result = op_a & op_b;
      barrel_pkg::ALU_OR:     result = op_a | op_b;
      barrel_pkg::ALU_XOR:    result = op_a ^ op_b;
      barrel_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      barrel_pkg::ALU_SLTU:   result = {31'b0, op_a < op_b};
      barrel_pkg::ALU_SLL:    result = op_a << op_b[4:0];
      barrel_pkg::ALU_SRL:    result = op_a >> op_b[4:0];
      barrel_pkg::ALU_SRA:    result = $signed(op_a) >>> op_b[4:0];
      barrel_pkg::ALU_PASS_B: result = op_b;
      default:                result = op_a + op_b;
    endcase
  end

  // branch condition on the raw register operands
  always_comb begin
    case (i_funct3)
      3'b000:  br_cond = (i_rs1 == i_rs2);
      3'b001:  br_cond = (i_rs1 != i_rs2);
      3'b100:  br_cond = ($signed(i_rs1) < $signed(i_rs2));
      3'b101:  br_cond = ($signed(i_rs1) >= $signed(i_rs2));
      3'b110:  br_cond = (i_rs1 < i_rs2);
      3'b111:  br_cond = (i_rs1 >= i_rs2);
      default: br_cond = 1'b0;
    endcase
  end

  // ------------------------------
  // next pc back to fetch
  assign link   = i_pc + 32'd4;
  assign target = i_is_jalr ? {result[barrel_pkg::XLEN-1:1], 1'b0} : result;
  assign taken  = i_is_jump | (i_is_branch & br_cond);

  assign o_pc_wr_en     = i_valid;
  assign o_pc_wr_thread = i_thread;
  assign o_pc_wr_data   = taken ? target : link;

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (reset) begin
      o_mem_valid    <= 1'b0;
      o_mem_is_store <= 1'b0;
      o_mem_rd_we    <= 1'b0;
    end else begin
      o_mem_valid    <= i_valid;
      o_mem_is_store <= i_is_store;
      o_mem_rd_we    <= i_rd_we;
    end
    o_mem_thread     <= i_thread;
    o_mem_result     <= result;
    o_mem_store_data <= i_rs2;
    o_mem_wb_sel     <= i_wb_sel;
    o_mem_link       <= link;
    o_mem_rd         <= i_rd;
  end

endmodule

// ==== mem_writeback.sv ====
/* data memory drive, write-back stage register and the write-back mux */
`timescale 1ns/1ns

module mem_writeback (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_valid,
  input  barrel_pkg::thread_t                 i_thread,
  input  logic [barrel_pkg::XLEN-1:0]         i_result,
  input  logic [barrel_pkg::XLEN-1:0]         i_store_data,
  input  logic                                i_is_store,
  input  barrel_pkg::wb_sel_t                 i_wb_sel,
  input  logic [barrel_pkg::XLEN-1:0]         i_link,
  input  logic [barrel_pkg::REG_ADDR_W-1:0]   i_rd,
  input  logic                                i_rd_we,
  input  logic [barrel_pkg::XLEN-1:0]         i_dmem_rdata,
  output logic [barrel_pkg::DMEM_ADDR_W-1:0]  o_dmem_addr,
  output logic [barrel_pkg::XLEN-1:0]         o_dmem_wdata,
  output logic                                o_dmem_we,
  rf_wr_if.src                                wb
);

  logic                              wb_en_q;
  barrel_pkg::thread_t               wb_thread_q;
  logic [barrel_pkg::REG_ADDR_W-1:0] wb_rd_q;
  barrel_pkg::wb_sel_t               wb_sel_q;
  logic [barrel_pkg::XLEN-1:0]       wb_result_q, wb_link_q;

  // word address, byte offset dropped
  assign o_dmem_addr  = i_result[barrel_pkg::DMEM_ADDR_W+1:2];
  assign o_dmem_wdata = i_store_data;
  assign o_dmem_we    = i_valid & i_is_store;

  // hold the controls while the read comes back
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en_q <= 1'b0;
    end else begin
      wb_en_q <= i_valid & i_rd_we;
    end
    wb_thread_q <= i_thread;
    wb_rd_q     <= i_rd;
    wb_sel_q    <= i_wb_sel;
    wb_result_q <= i_result;
    wb_link_q   <= i_link;
  end

  // ------------------------------
  always_comb begin
    case (wb_sel_q)
      barrel_pkg::WB_MEM:  wb.data = i_dmem_rdata;
      barrel_pkg::WB_LINK: wb.data = wb_link_q;
      default:             wb.data = wb_result_q;
    endcase
  end

  assign wb.wr_en  = wb_en_q;
  assign wb.thread = wb_thread_q;
  assign wb.addr   = wb_rd_q;

endmodule

// ==== barrel_core.sv ====
/* barrel-threaded RV32I core top, stage instances and wiring */
`timescale 1ns/1ns

module barrel_core (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [barrel_pkg::XLEN-1:0]         i_rom_data,
  input  logic [barrel_pkg::XLEN-1:0]         i_dmem_rdata,
  output logic [barrel_pkg::ROM_ADDR_W-1:0]   o_rom_addr,
  output logic [barrel_pkg::DMEM_ADDR_W-1:0]  o_dmem_addr,
  output logic [barrel_pkg::XLEN-1:0]         o_dmem_wdata,
  output logic                                o_dmem_we,
  output logic                                o_rf_wr_en,
  output barrel_pkg::thread_t                 o_rf_wr_thread,
  output logic [barrel_pkg::REG_ADDR_W-1:0]   o_rf_wr_addr,
  output logic [barrel_pkg::XLEN-1:0]         o_rf_wr_data
);

  // fetch to decode
  logic                               if_valid;
  barrel_pkg::thread_t                if_thread, rs_thread, pc_wr_thread;
  logic [barrel_pkg::XLEN-1:0]        if_pc, pc_wr_data, rs1_data, rs2_data;
  logic                               pc_wr_en;
  logic [barrel_pkg::REG_ADDR_W-1:0]  rs1_addr, rs2_addr;

  // decode to execute
  logic                               ex_valid, ex_src_a_pc, ex_src_b_imm, ex_is_branch;
  logic                               ex_is_jump, ex_is_jalr, ex_is_store, ex_rd_we;
  barrel_pkg::thread_t                ex_thread;
  logic [barrel_pkg::XLEN-1:0]        ex_pc, ex_rs1, ex_rs2, ex_imm;
  barrel_pkg::alu_op_t                ex_alu_op;
  logic [2:0]                         ex_funct3;
  barrel_pkg::wb_sel_t                ex_wb_sel;
  logic [barrel_pkg::REG_ADDR_W-1:0]  ex_rd;

  // execute to memory
  logic                               mem_valid, mem_is_store, mem_rd_we;
  barrel_pkg::thread_t                mem_thread;
  logic [barrel_pkg::XLEN-1:0]        mem_result, mem_store_data, mem_link;
  barrel_pkg::wb_sel_t                mem_wb_sel;
  logic [barrel_pkg::REG_ADDR_W-1:0]  mem_rd;

  rf_wr_if rf_wr ();

  thread_fetch u_fetch (
    .clk, .reset,
    .i_pc_wr_en(pc_wr_en), .i_pc_wr_thread(pc_wr_thread), .i_pc_wr_data(pc_wr_data),
    .o_rom_addr, .o_valid(if_valid), .o_thread(if_thread), .o_pc(if_pc)
  );

  inst_decode u_decode (
    .clk, .reset,
    .i_valid(if_valid), .i_thread(if_thread), .i_pc(if_pc), .i_inst(i_rom_data),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rs_thread(rs_thread),
    .o_ex_valid(ex_valid), .o_ex_thread(ex_thread), .o_ex_pc(ex_pc),
    .o_ex_rs1(ex_rs1), .o_ex_rs2(ex_rs2), .o_ex_imm(ex_imm), .o_ex_alu_op(ex_alu_op),
    .o_ex_src_a_pc(ex_src_a_pc), .o_ex_src_b_imm(ex_src_b_imm), .o_ex_funct3(ex_funct3),
    .o_ex_is_branch(ex_is_branch), .o_ex_is_jump(ex_is_jump), .o_ex_is_jalr(ex_is_jalr),
    .o_ex_is_store(ex_is_store), .o_ex_wb_sel(ex_wb_sel), .o_ex_rd(ex_rd),
    .o_ex_rd_we(ex_rd_we)
  );

  thread_regfile u_regfile (
    .clk,
    .i_rd_thread(rs_thread), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .wr(rf_wr.dst)
  );

  execute_unit u_execute (
    .clk, .reset,
    .i_valid(ex_valid), .i_thread(ex_thread), .i_pc(ex_pc), .i_rs1(ex_rs1),
    .i_rs2(ex_rs2), .i_imm(ex_imm), .i_alu_op(ex_alu_op), .i_src_a_pc(ex_src_a_pc),
    .i_src_b_imm(ex_src_b_imm), .i_funct3(ex_funct3), .i_is_branch(ex_is_branch),
    .i_is_jump(ex_is_jump), .i_is_jalr(ex_is_jalr), .i_is_store(ex_is_store),
    .i_wb_sel(ex_wb_sel), .i_rd(ex_rd), .i_rd_we(ex_rd_we),
    .o_pc_wr_en(pc_wr_en), .o_pc_wr_thread(pc_wr_thread), .o_pc_wr_data(pc_wr_data),
    .o_mem_valid(mem_valid), .o_mem_thread(mem_thread), .o_mem_result(mem_result),
    .o_mem_store_data(mem_store_data), .o_mem_is_store(mem_is_store),
    .o_mem_wb_sel(mem_wb_sel), .o_mem_link(mem_link), .o_mem_rd(mem_rd),
    .o_mem_rd_we(mem_rd_we)
  );

  mem_writeback u_writeback (
    .clk, .reset,
    .i_valid(mem_valid), .i_thread(mem_thread), .i_result(mem_result),
    .i_store_data(mem_store_data), .i_is_store(mem_is_store), .i_wb_sel(mem_wb_sel),
    .i_link(mem_link), .i_rd(mem_rd), .i_rd_we(mem_rd_we), .i_dmem_rdata,
    .o_dmem_addr, .o_dmem_wdata, .o_dmem_we,
    .wb(rf_wr.src)
  );

  // debug copy of the write-back bus
  assign o_rf_wr_en     = rf_wr.wr_en;
  assign o_rf_wr_thread = rf_wr.thread;
  assign o_rf_wr_addr   = rf_wr.addr;
  assign o_rf_wr_data   = rf_wr.data;

endmodule

// ==== barrel_core_checker.sv ====
/* concurrent assertions on the core's write-back and store outputs */
`timescale 1ns/1ns

module barrel_core_checker (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_rf_wr_en,
  input  logic                                i_dmem_we,
  input  logic [barrel_pkg::REG_ADDR_W-1:0]   i_rf_wr_addr,
  input  barrel_pkg::thread_t                 i_rf_wr_thread
);

  // quiet once reset has been seen for a full cycle
  a_reset_quiet: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!i_rf_wr_en && !i_dmem_we))
    else $error("write-back or store active during reset");

  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    i_rf_wr_en |-> (i_rf_wr_addr != '0))
    else $error("write-back to x0");

  // back-to-back write-backs come from neighbouring threads
  a_round_robin: assert property (@(posedge clk) disable iff (reset)
    (i_rf_wr_en && $past(i_rf_wr_en)) |->
      (i_rf_wr_thread ==
       barrel_pkg::thread_t'((int'($past(i_rf_wr_thread)) + 1) % barrel_pkg::NUM_THREADS)))
    else $error("write-back thread order broken");

endmodule

bind barrel_core barrel_core_checker i_checker (
  .clk(clk),
  .reset(reset),
  .i_rf_wr_en(o_rf_wr_en),
  .i_dmem_we(o_dmem_we),
  .i_rf_wr_addr(o_rf_wr_addr),
  .i_rf_wr_thread(o_rf_wr_thread)
);

// ==== barrel_core_tb.sv ====
/* testbench for the barrel core: program table with expected write-backs,
   ROM and RAM models, write-back and store checking, verdict */
`timescale 1ns/1ns

module barrel_core_tb;

  localparam int NUM_ROWS     = 23;
  localparam int TIMEOUT      = 2000;
  localparam int QUIET_CYCLES = 64;
  localparam int ROM_WORDS    = 2 ** barrel_pkg::ROM_ADDR_W;
  localparam int RAM_WORDS    = 2 ** barrel_pkg::DMEM_ADDR_W;

  // registers of the two instructions that are jumped over
  localparam logic [4:0]  SKIP_RD_BR  = 5'd15;
  localparam logic [4:0]  SKIP_RD_JAL = 5'd18;
  // sw x1, 64(x0)
  localparam logic [13:0] STORE_WORD  = 14'd16;
  localparam logic [31:0] STORE_DATA  = 32'h12345678;

  // ------------------------------
  // instruction, write flag, rd, expected value
  localparam logic [69:0] PROG [NUM_ROWS] = '{
    {32'h123450B7, 1'b1, 5'd1,  32'h12345000},  // lui  x1, 0x12345
    {32'h67808093, 1'b1, 5'd1,  32'h12345678},  // addi x1, x1, 0x678
    {32'hFF000113, 1'b1, 5'd2,  32'hFFFFFFF0},  // addi x2, x0, -16
    {32'h00500193, 1'b1, 5'd3,  32'h00000005},  // addi x3, x0, 5
    {32'h00208233, 1'b1, 5'd4,  32'h12345668},  // add  x4, x1, x2
    {32'h402082B3, 1'b1, 5'd5,  32'h12345688},  // sub  x5, x1, x2
    {32'h0020F333, 1'b1, 5'd6,  32'h12345670},  // and  x6, x1, x2
    {32'h0020E3B3, 1'b1, 5'd7,  32'hFFFFFFF8},  // or   x7, x1, x2
    {32'h0020C433, 1'b1, 5'd8,  32'hEDCBA988},  // xor  x8, x1, x2
    {32'h003124B3, 1'b1, 5'd9,  32'h00000001},  // slt  x9, x2, x3
    {32'h00313533, 1'b1, 5'd10, 32'h00000000},  // sltu x10, x2, x3
    {32'h003095B3, 1'b1, 5'd11, 32'h468ACF00},  // sll  x11, x1, x3
    {32'h00315633, 1'b1, 5'd12, 32'h07FFFFFF},  // srl  x12, x2, x3
    {32'h403156B3, 1'b1, 5'd13, 32'hFFFFFFFF},  // sra  x13, x2, x3
    {32'h04102023, 1'b0, 5'd0,  32'h00000000},  // sw   x1, 64(x0)
    {32'h04002703, 1'b1, 5'd14, 32'h12345678},  // lw   x14, 64(x0)
    {32'h00170463, 1'b0, 5'd0,  32'h00000000},  // beq  x14, x1, +8
    {32'h00100793, 1'b0, 5'd0,  32'h00000000},  // addi x15, x0, 1 (skipped)
    {32'h00001817, 1'b1, 5'd16, 32'h00001048},  // auipc x16, 0x1
    {32'h008008EF, 1'b1, 5'd17, 32'h00000050},  // jal  x17, +8
    {32'h00200913, 1'b0, 5'd0,  32'h00000000},  // addi x18, x0, 2 (skipped)
    {32'h00700993, 1'b1, 5'd19, 32'h00000007},  // addi x19, x0, 7
    {32'h0000006F, 1'b0, 5'd0,  32'h00000000}   // jal  x0, 0
  };

  logic                                clk;
  logic                                reset;
  logic [barrel_pkg::XLEN-1:0]         i_rom_data;
  logic [barrel_pkg::XLEN-1:0]         i_dmem_rdata;
  logic [barrel_pkg::ROM_ADDR_W-1:0]   o_rom_addr;
  logic [barrel_pkg::DMEM_ADDR_W-1:0]  o_dmem_addr;
  logic [barrel_pkg::XLEN-1:0]         o_dmem_wdata;
  logic                                o_dmem_we;
  logic                                o_rf_wr_en;
  barrel_pkg::thread_t                 o_rf_wr_thread;
  logic [barrel_pkg::REG_ADDR_W-1:0]   o_rf_wr_addr;
  logic [barrel_pkg::XLEN-1:0]         o_rf_wr_data;

  logic [31:0] rom [ROM_WORDS];
  logic [31:0] ram [RAM_WORDS];
  logic [4:0]  exp_rd [NUM_ROWS];
  logic [31:0] exp_val [NUM_ROWS];
  int          n_exp;
  int          exp_idx [barrel_pkg::NUM_THREADS];
  int          mismatch_count;
  int          other_count;
  int          store_count;

  barrel_core i_dut (
    .clk(clk), .reset(reset),
    .i_rom_data(i_rom_data), .i_dmem_rdata(i_dmem_rdata),
    .o_rom_addr(o_rom_addr), .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
    .o_dmem_we(o_dmem_we), .o_rf_wr_en(o_rf_wr_en), .o_rf_wr_thread(o_rf_wr_thread),
    .o_rf_wr_addr(o_rf_wr_addr), .o_rf_wr_data(o_rf_wr_data)
  );

  always #2 clk = ~clk;

  // memories answer one cycle after the address
  always @(posedge clk) begin
    i_rom_data <= rom[o_rom_addr];
  end

  always @(posedge clk) begin
    if (o_dmem_we) begin
      ram[o_dmem_addr] <= o_dmem_wdata;
    end
    i_dmem_rdata <= ram[o_dmem_addr];
  end

  function automatic logic all_threads_done();
    for (int t = 0; t < barrel_pkg::NUM_THREADS; t++) begin
      if (exp_idx[t] < n_exp) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // ------------------------------
  // write-back and store monitor, mid-cycle
  always @(negedge clk) begin
    int th;
    int k;
    if (!reset && o_rf_wr_en) begin
      th = int'(o_rf_wr_thread);
      k  = exp_idx[th];
      if (o_rf_wr_addr == SKIP_RD_BR || o_rf_wr_addr == SKIP_RD_JAL) begin
        other_count++;
        $display("thread %0d wrote x%0d from an instruction that was jumped over",
                 th, o_rf_wr_addr);
      end
      if (k >= n_exp) begin
        other_count++;
        $display("thread %0d wrote x%0d after reaching its self-loop", th, o_rf_wr_addr);
      end else begin
        if (o_rf_wr_addr != exp_rd[k]) begin
          mismatch_count++;
          $display("MISMATCH thread %0d write %0d o_rf_wr_addr got 0x%h expected 0x%h",
                   th, k, o_rf_wr_addr, exp_rd[k]);
        end
        if (o_rf_wr_data != exp_val[k]) begin
          mismatch_count++;
          $display("MISMATCH thread %0d write %0d o_rf_wr_data got 0x%h expected 0x%h",
                   th, k, o_rf_wr_data, exp_val[k]);
        end
        exp_idx[th] = k + 1;
      end
    end
    if (!reset && o_dmem_we) begin
      store_count++;
      if (o_dmem_addr != STORE_WORD) begin
        mismatch_count++;
        $display("MISMATCH o_dmem_addr got 0x%h expected 0x%h", o_dmem_addr, STORE_WORD);
      end
      if (o_dmem_wdata != STORE_DATA) begin
        mismatch_count++;
        $display("MISMATCH o_dmem_wdata got 0x%h expected 0x%h", o_dmem_wdata, STORE_DATA);
      end
    end
  end

  // ------------------------------
  initial begin
    int cycles;
    clk            = 1'b0;
    reset          = 1'b1;
    i_rom_data     = '0;
    i_dmem_rdata   = '0;
    mismatch_count = 0;
    other_count    = 0;
    store_count    = 0;
    void'($urandom(32'h353a));

    // filler is addi x31, x0, <word address>
    // a thread that runs past its self-loop shows up as a write
    for (int a = 0; a < ROM_WORDS; a++) begin
      rom[a] = {12'(a), 5'd0, 3'b000, 5'd31, 7'b0010011};
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      rom[r] = PROG[r][69:38];
    end
    for (int a = 0; a < RAM_WORDS; a++) begin
      ram[a] = $urandom();
    end

    // expected write-back sequence of every thread
    n_exp = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (PROG[r][37]) begin
        exp_rd[n_exp]  = PROG[r][36:32];
        exp_val[n_exp] = PROG[r][31:0];
        n_exp++;
      end
    end
    for (int t = 0; t < barrel_pkg::NUM_THREADS; t++) begin
      exp_idx[t] = 0;
    end

    repeat (3) @(posedge clk);
    reset <= 1'b0;

    cycles = 0;
    while (!all_threads_done() && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end

    if (!all_threads_done()) begin
      for (int t = 0; t < barrel_pkg::NUM_THREADS; t++) begin
        if (exp_idx[t] < n_exp) begin
          other_count++;
          $display("timeout: thread %0d gave only %0d of %0d write-backs",
                   t, exp_idx[t], n_exp);
        end
      end
    end else begin
      // threads sit in the self-loop, nothing more may be written
      cycles = 0;
      while (cycles < QUIET_CYCLES) begin
        @(posedge clk);
        cycles++;
      end
    end

    if (store_count != barrel_pkg::NUM_THREADS) begin
      other_count++;
      $display("saw %0d stores, one per thread was expected", store_count);
    end

    $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
barrel_pkg.sv
rf_wr_if.sv
thread_fetch.sv
inst_decode.sv
thread_regfile.sv
execute_unit.sv
mem_writeback.sv
barrel_core.sv
barrel_core_checker.sv
barrel_core_tb.sv

// ==== Makefile ====
TOP := barrel_core_tb
LOG := sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
